// ==== common/rv_exec_pkg.sv ====
`default_nettype none

package rv_exec_pkg;

  localparam int xlen = 32;

  // Major opcodes
  localparam logic [6:0] opcode_op     = 7'b0110011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;

  // funct7 selects the operation group
  localparam logic [6:0] funct7_base   = 7'b0000000;
  localparam logic [6:0] funct7_alt    = 7'b0100000; // SUB, SRA
  localparam logic [6:0] funct7_muldiv = 7'b0000001;

  // Base integer funct3
  localparam logic [2:0] funct3_add_sub = 3'b000;
  localparam logic [2:0] funct3_sll     = 3'b001;
  localparam logic [2:0] funct3_slt     = 3'b010;
  localparam logic [2:0] funct3_sltu    = 3'b011;
  localparam logic [2:0] funct3_xor     = 3'b100;
  localparam logic [2:0] funct3_srl_sra = 3'b101;
  localparam logic [2:0] funct3_or      = 3'b110;
  localparam logic [2:0] funct3_and     = 3'b111;

  // M extension funct3
  localparam logic [2:0] funct3_mul    = 3'b000;
  localparam logic [2:0] funct3_mulh   = 3'b001;
  localparam logic [2:0] funct3_mulhsu = 3'b010;
  localparam logic [2:0] funct3_mulhu  = 3'b011;
  localparam logic [2:0] funct3_div    = 3'b100;
  localparam logic [2:0] funct3_divu   = 3'b101;
  localparam logic [2:0] funct3_rem    = 3'b110;
  localparam logic [2:0] funct3_remu   = 3'b111;

  typedef enum logic [4:0] {
    op_add,
    op_sub,
    op_sll,
    op_slt,
    op_sltu,
    op_xor,
    op_srl,
    op_sra,
    op_or,
    op_and,
    op_mul,
    op_mulh,
    op_mulhsu,
    op_mulhu,
    op_div,
    op_divu,
    op_rem,
    op_remu,
    op_none      // Illegal or unsupported
  } alu_op_e;

  // Same word seen as register form and immediate form
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
  } instr_t;

endpackage

`default_nettype wire

// ==== rtl/instr_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module instr_decoder (
  input  rv_exec_pkg::instr_t               instr,
  input  logic [rv_exec_pkg::xlen-1:0]      rs2,
  output rv_exec_pkg::alu_op_e              op,
  output logic [rv_exec_pkg::xlen-1:0]      operand_b,
  output logic [4:0]                        shamt,
  output logic                              illegal
);

  logic [rv_exec_pkg::xlen-1:0] imm_ext;

  assign imm_ext = {{(rv_exec_pkg::xlen-12){instr.i.imm[11]}}, instr.i.imm};

  always_comb begin
    op        = rv_exec_pkg::op_none;
    illegal   = 1'b1;
    operand_b = rs2;
    case (instr.r.opcode)
      rv_exec_pkg::opcode_op: begin
        case (instr.r.funct7)
          rv_exec_pkg::funct7_base: begin
            illegal = 1'b0;
            case (instr.r.funct3)
              rv_exec_pkg::funct3_add_sub: op = rv_exec_pkg::op_add;
              rv_exec_pkg::funct3_sll:     op = rv_exec_pkg::op_sll;
              rv_exec_pkg::funct3_slt:     op = rv_exec_pkg::op_slt;
              rv_exec_pkg::funct3_sltu:    op = rv_exec_pkg::op_sltu;
              rv_exec_pkg::funct3_xor:     op = rv_exec_pkg::op_xor;
              rv_exec_pkg::funct3_srl_sra: op = rv_exec_pkg::op_srl;
              rv_exec_pkg::funct3_or:      op = rv_exec_pkg::op_or;
              default:                     op = rv_exec_pkg::op_and;
            endcase
          end
          rv_exec_pkg::funct7_alt: begin
            // Only SUB and SRA have an alternate encoding
            if (instr.r.funct3 == rv_exec_pkg::funct3_add_sub) begin
              op      = rv_exec_pkg::op_sub;
              illegal = 1'b0;
            end else if (instr.r.funct3 == rv_exec_pkg::funct3_srl_sra) begin
              op      = rv_exec_pkg::op_sra;
              illegal = 1'b0;
            end
          end
          rv_exec_pkg::funct7_muldiv: begin
            illegal = 1'b0;
            case (instr.r.funct3)
              rv_exec_pkg::funct3_mul:    op = rv_exec_pkg::op_mul;
              rv_exec_pkg::funct3_mulh:   op = rv_exec_pkg::op_mulh;
              rv_exec_pkg::funct3_mulhsu: op = rv_exec_pkg::op_mulhsu;
              rv_exec_pkg::funct3_mulhu:  op = rv_exec_pkg::op_mulhu;
              rv_exec_pkg::funct3_div:    op = rv_exec_pkg::op_div;
              rv_exec_pkg::funct3_divu:   op = rv_exec_pkg::op_divu;
              rv_exec_pkg::funct3_rem:    op = rv_exec_pkg::op_rem;
              default:                    op = rv_exec_pkg::op_remu;
            endcase
          end
          default: ;
        endcase
      end
      rv_exec_pkg::opcode_op_imm: begin
        operand_b = imm_ext;
        illegal   = 1'b0;
        case (instr.i.funct3)
          rv_exec_pkg::funct3_add_sub: op = rv_exec_pkg::op_add; // No SUBI
          rv_exec_pkg::funct3_sll:     op = rv_exec_pkg::op_sll;
          rv_exec_pkg::funct3_slt:     op = rv_exec_pkg::op_slt;
          rv_exec_pkg::funct3_sltu:    op = rv_exec_pkg::op_sltu;
          rv_exec_pkg::funct3_xor:     op = rv_exec_pkg::op_xor;
          rv_exec_pkg::funct3_or:      op = rv_exec_pkg::op_or;
          rv_exec_pkg::funct3_and:     op = rv_exec_pkg::op_and;
          default: begin
            // Upper immediate bits pick SRLI or SRAI
            if (instr.r.funct7 == rv_exec_pkg::funct7_base) begin
              op = rv_exec_pkg::op_srl;
            end else if (instr.r.funct7 == rv_exec_pkg::funct7_alt) begin
              op = rv_exec_pkg::op_sra;
            end else begin
              illegal = 1'b1;
            end
          end
        endcase
      end
      default: ;
    endcase
  end

  assign shamt = operand_b[4:0];

  a_illegal_is_none: assert final ((op == rv_exec_pkg::op_none) == illegal);

endmodule

`default_nettype wire

// ==== alu/mul_div.sv ====
`timescale 1ns/1ns
`default_nettype none

module mul_div (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          start,
  input  rv_exec_pkg::alu_op_e          op,
  input  logic [rv_exec_pkg::xlen-1:0]  a,
  input  logic [rv_exec_pkg::xlen-1:0]  b,
  output logic                          busy,
  output logic                          done,
  output logic [rv_exec_pkg::xlen-1:0]  result
);

  logic [6:0]                      cnt;
  logic [6:0]                      cnt_init;
  rv_exec_pkg::alu_op_e            op_q;
  logic                            is_mul_q;
  logic                            signed_div;

  // Multiplier datapath
  logic [2*rv_exec_pkg::xlen-1:0]  mcand;
  logic [2*rv_exec_pkg::xlen-1:0]  mplier;
  logic [2*rv_exec_pkg::xlen-1:0]  acc;
  logic [2*rv_exec_pkg::xlen-1:0]  acc_next;

  // Divider datapath
  logic [rv_exec_pkg::xlen-1:0]    a_abs;
  logic [rv_exec_pkg::xlen-1:0]    b_abs;
  logic [rv_exec_pkg::xlen-1:0]    quo;
  logic [rv_exec_pkg::xlen-1:0]    rem;
  logic [rv_exec_pkg::xlen-1:0]    dvsr;
  logic [rv_exec_pkg::xlen:0]      shifted;
  logic [rv_exec_pkg::xlen:0]      diff;
  logic                            fits;
  logic                            neg_q;
  logic                            neg_r;

  assign signed_div = (op == rv_exec_pkg::op_div) || (op == rv_exec_pkg::op_rem);
  assign a_abs = (signed_div && a[rv_exec_pkg::xlen-1]) ? -a : a;
  assign b_abs = (signed_div && b[rv_exec_pkg::xlen-1]) ? -b : b;

  // MUL needs only the low half, so 32 steps; divide adds a sign-fix step
  assign cnt_init = (op == rv_exec_pkg::op_mul) ? 7'd32 :
                    (op inside {rv_exec_pkg::op_mulh, rv_exec_pkg::op_mulhsu,
                                rv_exec_pkg::op_mulhu}) ? 7'd64 : 7'd33;

  assign is_mul_q = op_q inside {rv_exec_pkg::op_mul, rv_exec_pkg::op_mulh,
                                 rv_exec_pkg::op_mulhsu, rv_exec_pkg::op_mulhu};

  assign acc_next = mplier[0] ? acc + mcand : acc;

  assign shifted = {rem, quo[rv_exec_pkg::xlen-1]};
  assign diff    = shifted - {1'b0, dvsr};
  assign fits    = shifted >= {1'b0, dvsr};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy <= 1'b0;
      done <= 1'b0;
      cnt  <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        cnt  <= cnt_init;
      end else if (busy) begin
        cnt <= cnt - 7'd1;
        if (cnt == 7'd1) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      op_q <= op;
      acc  <= '0;
      case (op)
        rv_exec_pkg::op_mulh: begin
          mcand  <= {{rv_exec_pkg::xlen{a[rv_exec_pkg::xlen-1]}}, a};
          mplier <= {{rv_exec_pkg::xlen{b[rv_exec_pkg::xlen-1]}}, b};
        end
        rv_exec_pkg::op_mulhsu: begin
          mcand  <= {{rv_exec_pkg::xlen{a[rv_exec_pkg::xlen-1]}}, a};
          mplier <= {{rv_exec_pkg::xlen{1'b0}}, b};
        end
        default: begin
          mcand  <= {{rv_exec_pkg::xlen{1'b0}}, a};
          mplier <= {{rv_exec_pkg::xlen{1'b0}}, b};
        end
      endcase
      rem   <= '0;
      quo   <= a_abs;
      dvsr  <= b_abs;
      neg_q <= signed_div && (a[rv_exec_pkg::xlen-1] ^ b[rv_exec_pkg::xlen-1]) && (b != '0);
      neg_r <= signed_div && a[rv_exec_pkg::xlen-1];
    end else if (busy) begin
      if (is_mul_q) begin
        acc    <= acc_next;
        mcand  <= mcand << 1;
        mplier <= mplier >> 1;
        if (cnt == 7'd1) begin
          result <= (op_q == rv_exec_pkg::op_mul) ? acc_next[rv_exec_pkg::xlen-1:0]
                                                  : acc_next[2*rv_exec_pkg::xlen-1:rv_exec_pkg::xlen];
        end
      end else if (cnt != 7'd1) begin
        // One restoring step
        rem <= fits ? diff[rv_exec_pkg::xlen-1:0] : shifted[rv_exec_pkg::xlen-1:0];
        quo <= {quo[rv_exec_pkg::xlen-2:0], fits};
      end else begin
        case (op_q)
          rv_exec_pkg::op_div:  result <= neg_q ? -quo : quo;
          rv_exec_pkg::op_rem:  result <= neg_r ? -rem : rem;
          rv_exec_pkg::op_remu: result <= rem;
          default:              result <= quo;
        endcase
      end
    end
  end

  a_cnt_no_wrap: assert property (
    @(posedge clk) disable iff (!rst_n) busy |-> (cnt != '0)
  );

  a_done_after_busy: assert property (
    @(posedge clk) disable iff (!rst_n) done |-> $past(busy)
  );

endmodule

`default_nettype wire

// ==== alu/alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          valid,
  input  rv_exec_pkg::alu_op_e          op,
  input  logic [rv_exec_pkg::xlen-1:0]  rs1,
  input  logic [rv_exec_pkg::xlen-1:0]  operand_b,
  input  logic [4:0]                    shamt,
  output logic                          ready,
  output logic [rv_exec_pkg::xlen-1:0]  result
);

  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_wait = 2'd1;
  localparam logic [1:0] st_done = 2'd2;

  logic [1:0]                    state;
  logic                          is_md;
  logic                          start;
  logic                          md_busy;
  logic                          md_done;
  logic [rv_exec_pkg::xlen-1:0]  md_result;
  logic [rv_exec_pkg::xlen-1:0]  simple_res;

  assign is_md = op inside {rv_exec_pkg::op_mul, rv_exec_pkg::op_mulh,
                            rv_exec_pkg::op_mulhsu, rv_exec_pkg::op_mulhu,
                            rv_exec_pkg::op_div, rv_exec_pkg::op_divu,
                            rv_exec_pkg::op_rem, rv_exec_pkg::op_remu};

  // Launch multiply/divide straight from idle
  assign start = (state == st_idle) && valid && is_md;

  always_comb begin
    case (op)
      rv_exec_pkg::op_add:  simple_res = rs1 + operand_b;
      rv_exec_pkg::op_sub:  simple_res = rs1 - operand_b;
      rv_exec_pkg::op_sll:  simple_res = rs1 << shamt;
      rv_exec_pkg::op_slt:  simple_res = {31'b0, $signed(rs1) < $signed(operand_b)};
      rv_exec_pkg::op_sltu: simple_res = {31'b0, rs1 < operand_b};
      rv_exec_pkg::op_xor:  simple_res = rs1 ^ operand_b;
      rv_exec_pkg::op_srl:  simple_res = rs1 >> shamt;
      rv_exec_pkg::op_sra:  simple_res = $signed(rs1) >>> shamt;
      rv_exec_pkg::op_or:   simple_res = rs1 | operand_b;
      rv_exec_pkg::op_and:  simple_res = rs1 & operand_b;
      default:              simple_res = '0; // Illegal returns zero
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= st_idle;
      ready  <= 1'b0;
      result <= '0;
    end else begin
      ready <= 1'b0;
      case (state)
        st_idle: begin
          if (valid) begin
            if (is_md) begin
              state <= st_wait;
            end else begin
              result <= simple_res;
              ready  <= 1'b1;
              state  <= st_done;
            end
          end
        end
        st_wait: begin
          if (md_done) begin
            result <= md_result;
            ready  <= 1'b1;
            state  <= st_done;
          end
        end
        default: begin
          // Hold until the requester drops valid
          if (!valid) state <= st_idle;
        end
      endcase
    end
  end

  mul_div u_mul_div (
    .clk    (clk),
    .rst_n  (rst_n),
    .start  (start),
    .op     (op),
    .a      (rs1),
    .b      (operand_b),
    .busy   (md_busy),
    .done   (md_done),
    .result (md_result)
  );

  a_ready_single: assert property (
    @(posedge clk) disable iff (!rst_n) ready |=> !ready
  );

  a_start_idle_unit: assert property (
    @(posedge clk) disable iff (!rst_n) start |-> !md_busy
  );

endmodule

`default_nettype wire

// ==== rtl/exec_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_unit (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          valid,
  input  rv_exec_pkg::instr_t           instr,
  input  logic [rv_exec_pkg::xlen-1:0]  rs1,
  input  logic [rv_exec_pkg::xlen-1:0]  rs2,
  output logic                          ready,
  output logic [rv_exec_pkg::xlen-1:0]  result,
  output logic                          illegal
);

  rv_exec_pkg::alu_op_e          op;
  logic [rv_exec_pkg::xlen-1:0]  operand_b;
  logic [4:0]                    shamt;

  // Decode is purely combinational
  instr_decoder u_decoder (
    .instr     (instr),
    .rs2       (rs2),
    .op        (op),
    .operand_b (operand_b),
    .shamt     (shamt),
    .illegal   (illegal)
  );

  alu u_alu (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid     (valid),
    .op        (op),
    .rs1       (rs1),
    .operand_b (operand_b),
    .shamt     (shamt),
    .ready     (ready),
    .result    (result)
  );

endmodule

`default_nettype wire

// ==== verification/tb_exec_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_exec_unit;

  localparam int period_ns   = 40;
  localparam int max_wait    = 100;
  localparam int watchdog_ns = 200 * 70 * period_ns;

  localparam logic [6:0] opc_reg = 7'b0110011;
  localparam logic [6:0] opc_imm = 7'b0010011;

  // Operation kinds, M group in funct3 order
  localparam int k_add = 0, k_sub = 1, k_sll = 2, k_slt = 3, k_sltu = 4, k_xor = 5,
                 k_srl = 6, k_sra = 7, k_or = 8, k_and = 9, k_mul = 10, k_mulh = 11,
                 k_mulhsu = 12, k_mulhu = 13, k_div = 14, k_divu = 15, k_rem = 16,
                 k_remu = 17;

  logic        clk;
  logic        rst_n;
  logic        valid;
  logic [31:0] instr;
  logic [31:0] rs1;
  logic [31:0] rs2;
  logic        ready;
  logic [31:0] result;
  logic        illegal;
  integer      seed;
  int          errors;

  exec_unit UUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .valid   (valid),
    .instr   (instr),
    .rs1     (rs1),
    .rs2     (rs2),
    .ready   (ready),
    .result  (result),
    .illegal (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  // {funct7, funct3} of each kind
  function automatic logic [9:0] funct_of(input int kind);
    if (kind >= k_mul) return {7'b0000001, 3'(kind - k_mul)};
    case (kind)
      k_sub:   return {7'b0100000, 3'b000};
      k_sll:   return {7'b0000000, 3'b001};
      k_slt:   return {7'b0000000, 3'b010};
      k_sltu:  return {7'b0000000, 3'b011};
      k_xor:   return {7'b0000000, 3'b100};
      k_srl:   return {7'b0000000, 3'b101};
      k_sra:   return {7'b0100000, 3'b101};
      k_or:    return {7'b0000000, 3'b110};
      k_and:   return {7'b0000000, 3'b111};
      default: return {7'b0000000, 3'b000};
    endcase
  endfunction

  function automatic int latency_of(input int kind);
    if (kind == k_mul) return 34;
    if (kind >= k_mulh && kind <= k_mulhu) return 66;
    if (kind >= k_div) return 35;
    return 1;
  endfunction

  // RISC-V reference results
  function automatic logic [31:0] ref_model(input int kind, input logic [31:0] a,
                                            input logic [31:0] b);
    logic [63:0] sa;
    logic [63:0] ua;
    logic [63:0] sb;
    logic [63:0] ub;
    logic [63:0] prod;
    logic        ovf;
    sa   = {{32{a[31]}}, a};
    ua   = {32'b0, a};
    sb   = {{32{b[31]}}, b};
    ub   = {32'b0, b};
    ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff); // Signed overflow pair
    prod = '0;
    case (kind)
      k_add:    return a + b;
      k_sub:    return a - b;
      k_sll:    return a << b[4:0];
      k_slt:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      k_sltu:   return (a < b) ? 32'd1 : 32'd0;
      k_xor:    return a ^ b;
      k_srl:    return a >> b[4:0];
      k_sra:    return $signed(a) >>> b[4:0];
      k_or:     return a | b;
      k_and:    return a & b;
      k_mul:    prod = ua * ub;
      k_mulh:   prod = sa * sb;
      k_mulhsu: prod = sa * ub;
      k_mulhu:  prod = ua * ub;
      k_div: begin
        if (b == 32'h0) return 32'hffff_ffff;
        if (ovf) return a;
        return $signed(a) / $signed(b);
      end
      k_rem: begin
        if (b == 32'h0) return a;
        if (ovf) return 32'h0;
        return $signed(a) % $signed(b);
      end
      k_divu:   return (b == 32'h0) ? 32'hffff_ffff : a / b;
      default:  return (b == 32'h0) ? a : a % b;
    endcase
    return (kind == k_mul) ? prod[31:0] : prod[63:32];
  endfunction

  task automatic run_op(input string name, input logic [31:0] word, input logic [31:0] a,
                        input logic [31:0] b, input logic [31:0] exp_res, input logic exp_ill,
                        input int exp_lat, input int hold);
    int   cycles;
    logic seen;
    @(posedge clk);
    instr <= word;
    rs1   <= a;
    rs2   <= b;
    valid <= 1'b1;
    @(posedge clk); // DUT samples valid here
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < max_wait) begin
      @(negedge clk);
      cycles++;
      seen = ready;
    end
    assert (seen) else begin
      errors++;
      $display("%s got no ready within %0d cycles at %0t", name, max_wait, $time);
    end
    if (seen) begin
      if (!exp_ill) begin
        assert (result === exp_res) else begin
          errors++;
          $display("Mismatch at %0t: %s result expected %h got %h", $time, name, exp_res, result);
        end
      end
      assert (illegal === exp_ill) else begin
        errors++;
        $display("Mismatch at %0t: %s illegal expected %b got %b", $time, name, exp_ill, illegal);
      end
      assert (cycles == exp_lat) else begin
        errors++;
        $display("Mismatch at %0t: %s latency expected %0d got %0d", $time, name, exp_lat, cycles);
      end
      repeat (hold) begin
        @(negedge clk);
        assert (!ready) else begin
          errors++;
          $display("%s raised ready again while valid stayed high at %0t", name, $time);
        end
      end
    end
    @(posedge clk);
    valid <= 1'b0;
    @(posedge clk);
  endtask

  task automatic check_reg(input int kind, input logic [31:0] a, input logic [31:0] b,
                           input int hold);
    logic [9:0] f;
    f = funct_of(kind);
    run_op($sformatf("R kind %0d", kind), {f[9:3], 5'd2, 5'd1, f[2:0], 5'd3, opc_reg},
           a, b, ref_model(kind, a, b), 1'b0, latency_of(kind), hold);
  endtask

  task automatic check_imm(input int kind, input logic [31:0] a, input logic [11:0] imm);
    logic [9:0]  f;
    logic [11:0] iv;
    logic [31:0] b;
    f  = funct_of(kind);
    iv = imm;
    // Shift immediates carry funct7 in the upper bits
    if (kind == k_sll || kind == k_srl || kind == k_sra) iv = {f[9:3], imm[4:0]};
    b = {{20{iv[11]}}, iv};
    run_op($sformatf("I kind %0d", kind), {iv, 5'd1, f[2:0], 5'd3, opc_imm}, a,
           $random(seed), ref_model(kind, a, b), 1'b0, 1, 0);
  endtask

  task automatic test_reset();
    @(negedge clk);
    assert (result === 32'h0) else begin
      errors++;
      $display("Mismatch at %0t: result expected %h got %h", $time, 32'h0, result);
    end
    repeat (4) begin
      @(negedge clk);
      assert (ready === 1'b0) else begin
        errors++;
        $display("Mismatch at %0t: ready expected %b got %b", $time, 1'b0, ready);
      end
    end
  endtask

  task automatic test_base();
    for (int k = k_add; k <= k_and; k++) begin
      repeat (3) check_reg(k, $random(seed), $random(seed), 0);
      check_reg(k, 32'h0, 32'hffff_ffff, 0);
      check_reg(k, 32'h8000_0000, 32'hffff_ffff, 0);
      check_reg(k, 32'hffff_ffff, 32'h8000_0000, 0);
    end
    check_reg(k_sll, 32'h8000_0001, 32'd0, 0);
    check_reg(k_sll, 32'h8000_0001, 32'd31, 0);
    check_reg(k_srl, 32'h8000_0001, 32'd0, 0);
    check_reg(k_srl, 32'h8000_0001, 32'd31, 0);
    check_reg(k_sra, 32'h8000_0001, 32'd0, 0);
    check_reg(k_sra, 32'h8000_0001, 32'd31, 0);
  endtask

  task automatic test_imm();
    int kinds [9];
    kinds = '{k_add, k_slt, k_sltu, k_xor, k_or, k_and, k_sll, k_srl, k_sra};
    foreach (kinds[i]) begin
      check_imm(kinds[i], $random(seed), 12'($random(seed)));
      check_imm(kinds[i], 32'h8000_0000, 12'hfff);
      check_imm(kinds[i], 32'h7fff_ffff, 12'h800); // Most negative immediate
    end
  endtask

  task automatic test_mul();
    for (int k = k_mul; k <= k_mulhu; k++) begin
      repeat (2) check_reg(k, $random(seed), $random(seed), 0);
      check_reg(k, 32'h8000_0000, 32'h8000_0000, 0);
      check_reg(k, 32'h8000_0000, 32'hffff_ffff, 0);
      check_reg(k, 32'hffff_ffff, 32'h7fff_ffff, 0);
    end
  endtask

  task automatic test_div();
    for (int k = k_div; k <= k_remu; k++) begin
      repeat (2) check_reg(k, $random(seed), $random(seed), 0);
      check_reg(k, 32'hffff_fff9, 32'd2, 0);
      check_reg(k, $random(seed), 32'h0, 0);
      check_reg(k, 32'h8000_0000, 32'hffff_ffff, 0);
    end
    // Valid held high longer than a second divide would take
    check_reg(k_div, 32'd100, 32'hffff_fffd, 40);
  endtask

  task automatic test_illegal();
    run_op("unknown opcode", {25'h0, 7'b1111111}, $random(seed), $random(seed),
           32'h0, 1'b1, 1, 0);
    run_op("unknown funct7", {7'b0000010, 5'd2, 5'd1, 3'b000, 5'd3, opc_reg},
           $random(seed), $random(seed), 32'h0, 1'b1, 1, 0);
    // M group funct7 on a right shift immediate
    run_op("bad shift immediate", {7'b0000001, 5'd4, 5'd1, 3'b101, 5'd3, opc_imm},
           $random(seed), $random(seed), 32'h0, 1'b1, 1, 0);
  endtask

  initial begin
    seed   = 32'h0de3_7adb;
    errors = 0;
    rst_n  = 1'b0;
    valid  = 1'b0;
    instr  = '0;
    rs1    = '0;
    rs2    = '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    test_reset();
    test_base();
    test_imm();
    test_mul();
    test_div();
    test_illegal();
    $display("Run complete, error count %0d", errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("Watchdog expired after %0d ns, the run timed out", watchdog_ns);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
common/rv_exec_pkg.sv
rtl/instr_decoder.sv
alu/mul_div.sv
alu/alu.sv
rtl/exec_unit.sv
verification/tb_exec_unit.sv

// ==== Bender.yml ====
package:
  name: rv_exec_unit

sources:
  - common/rv_exec_pkg.sv
  - rtl/instr_decoder.sv
  - alu/mul_div.sv
  - alu/alu.sv
  - rtl/exec_unit.sv
  - target: test
    files:
      - verification/tb_exec_unit.sv
